// File: include/spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clocking defaults
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SPI_CLKFREQ 50000000   // system clock in hz.
`define SPI_SPEED   5000000    // sclk rate in hz, gives a half period of 5 clk.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SPI_ADDR_DATA 4'h0     // data and status.
`define SPI_ADDR_SS   4'h2     // slave select, bit 0 only.
`define SPI_ADDR_CONF 4'h4     // cpha, cpol, lsb first.

`endif

// File: logic/spi_pkg.sv
package spi_pkg;

  // host bus side.
  typedef logic [15:0] data_word_t;
  typedef logic [3:0]  reg_addr_t;

  // one shifted byte.
  typedef logic [7:0]  spi_byte_t;

  // status cycle, also the top two bits of the status word.
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_BUSY     = 2'd1,
    ST_COMPLETE = 2'd2,
    ST_RELEASE  = 2'd3
  } xfer_state_t;

  typedef enum logic [1:0] {
    SH_IDLE,
    SH_RUN,
    SH_DONE
  } shift_state_t;

  // configuration register, upper bits are stored only.
  typedef struct packed {
    logic [12:0] spare;
    logic        lsb_first;
    logic        cpol;
    logic        cpha;
  } conf_t;

endpackage

// File: logic/spi_xfer_if.sv
`timescale 1ns/1ps

interface spi_xfer_if;
  import spi_pkg::*;

  logic      start;     // one cycle, only while the transceiver is idle.
  spi_byte_t tx_byte;   // held from start until done.
  conf_t     conf;      // held from start until done.
  spi_byte_t rx_byte;   // valid while done is high.
  logic      done;      // one cycle, once per start.

  // register block side.
  modport ctrl (
    output start,
    output tx_byte,
    output conf,
    input  rx_byte,
    input  done
  );

  // shifter side.
  modport xcvr (
    input  start,
    input  tx_byte,
    input  conf,
    output rx_byte,
    output done
  );

endinterface

// File: logic/spi_clk_gen.sv
`timescale 1ns/1ps

module spi_clk_gen #(
  parameter int half_period = 5
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic lead,
  output logic trail
);

  localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half_period - 1);

  logic [cnt_w-1:0] cnt;
  logic             phase;   // low means the next strobe is a lead edge.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      phase <= 1'b0;
      lead  <= 1'b0;
      trail <= 1'b0;
    end else if (!run) begin
      // hold everything at the start point between transfers.
      cnt   <= '0;
      phase <= 1'b0;
      lead  <= 1'b0;
      trail <= 1'b0;
    end else begin
      lead  <= 1'b0;
      trail <= 1'b0;
      if (cnt == cnt_last) begin
        cnt   <= '0;
        phase <= ~phase;
        lead  <= ~phase;
        trail <= phase;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/spi_xcvr.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_xcvr #(
  parameter int clkfreq = `SPI_CLKFREQ,
  parameter int speed   = `SPI_SPEED
) (
  input  logic     clk,
  input  logic     rst_n,
  spi_xfer_if.xcvr xfer,
  input  logic     miso,
  output logic     mosi,
  output logic     sclk
);
  import spi_pkg::*;

  localparam int div = clkfreq / (2 * speed);
  localparam int half_period = (div > 0) ? div : 1;

  shift_state_t state;
  spi_byte_t    tx_sr;
  spi_byte_t    tx_next;
  spi_byte_t    rx_sr;
  logic [3:0]   edge_cnt;      // sclk edges seen, 16 per byte.
  logic         start_q;       // tx_byte is latched one cycle after start.
  logic         run;
  logic         lead;
  logic         trail;
  logic         sample_edge;
  logic         shift_edge;

  assign run = (state == SH_RUN);

  spi_clk_gen #(
    .half_period(half_period)
  ) clk_gen_i (
    .clk  (clk),
    .rst_n(rst_n),
    .run  (run),
    .lead (lead),
    .trail(trail)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // edge roles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // cpha 0 samples on lead and shifts on trail.
  // cpha 1 shifts on lead, skipping the first since bit one is already out.
  assign sample_edge = xfer.conf.cpha ? trail : lead;
  assign shift_edge  = xfer.conf.cpha ? (lead && (edge_cnt != 4'd0)) : trail;

  assign tx_next = xfer.conf.lsb_first ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= SH_IDLE;
      start_q  <= 1'b0;
      edge_cnt <= '0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state)
        SH_IDLE: begin
          sclk     <= xfer.conf.cpol;   // idle level follows cpol.
          edge_cnt <= '0;
          start_q  <= xfer.start;
          if (start_q) begin
            mosi  <= xfer.conf.lsb_first ? xfer.tx_byte[0] : xfer.tx_byte[7];
            state <= SH_RUN;
          end
        end
        SH_RUN: begin
          if (lead || trail) begin
            sclk     <= ~sclk;
            edge_cnt <= edge_cnt + 1'b1;
          end
          if (shift_edge) begin
            mosi <= xfer.conf.lsb_first ? tx_next[0] : tx_next[7];
          end
          if (trail && (edge_cnt == 4'd15)) begin
            state <= SH_DONE;   // sclk is back at cpol here.
          end
        end
        SH_DONE: begin
          mosi  <= 1'b0;
          state <= SH_IDLE;
        end
        default: state <= SH_IDLE;
      endcase
    end
  end

  // data shifters.
  always_ff @(posedge clk) begin
    if ((state == SH_IDLE) && start_q) begin
      tx_sr <= xfer.tx_byte;
    end else if (run && shift_edge) begin
      tx_sr <= tx_next;
    end
    if (run && sample_edge) begin
      rx_sr <= xfer.conf.lsb_first ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
    end
  end

  assign xfer.done    = (state == SH_DONE);
  assign xfer.rx_byte = rx_sr;

endmodule

// File: logic/spi_master.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_master #(
  parameter int clkfreq = `SPI_CLKFREQ,
  parameter int speed   = `SPI_SPEED
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                select,
  input  logic                write,
  input  spi_pkg::reg_addr_t  address,
  input  spi_pkg::data_word_t data_in,
  output spi_pkg::data_word_t data_out,
  input  logic                miso,
  output logic                mosi,
  output logic                sclk,
  output logic                ss
);
  import spi_pkg::*;

  spi_byte_t   tx_byte_q, tx_byte_d;
  spi_byte_t   rx_byte_q, rx_byte_d;
  logic        ss_q, ss_d;
  conf_t       conf_q, conf_d;
  xfer_state_t state_q, state_d;
  logic        tx_start;

  spi_xfer_if xfer ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_byte_q <= '0;
      ss_q      <= 1'b1;        // slave deselected out of reset.
      conf_q    <= '0;
      state_q   <= ST_IDLE;
    end else begin
      rx_byte_q <= rx_byte_d;
      ss_q      <= ss_d;
      conf_q    <= conf_d;
      state_q   <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    tx_byte_q <= tx_byte_d;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus decode and status cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    tx_byte_d = tx_byte_q;
    rx_byte_d = rx_byte_q;
    ss_d      = ss_q;
    conf_d    = conf_q;
    state_d   = state_q;
    tx_start  = 1'b0;
    data_out  = '0;
    if (select && write) begin
      case (address)
        `SPI_ADDR_DATA: begin
          // data writes outside idle are dropped.
          if (state_q == ST_IDLE) begin
            state_d   = ST_BUSY;
            tx_start  = 1'b1;
            tx_byte_d = data_in[7:0];
          end
        end
        `SPI_ADDR_SS:   ss_d = data_in[0];
        `SPI_ADDR_CONF: conf_d = conf_t'(data_in);
        default: ;
      endcase
    end else if (select) begin
      case (address)
        `SPI_ADDR_DATA: begin
          data_out = {state_q, 6'h00, rx_byte_q};
          if (state_q == ST_COMPLETE) begin
            state_d = ST_RELEASE;   // software has seen the result.
          end
        end
        `SPI_ADDR_SS:   data_out = {15'h0000, ss_q};
        `SPI_ADDR_CONF: data_out = data_word_t'(conf_q);
        default:        data_out = '0;
      endcase
    end else if (state_q == ST_RELEASE) begin
      state_d = ST_IDLE;
    end

    if (xfer.done && (state_q == ST_BUSY)) begin
      rx_byte_d = xfer.rx_byte;
      state_d   = ST_COMPLETE;
    end
  end

  assign xfer.start   = tx_start;
  assign xfer.tx_byte = tx_byte_q;   // latched copy, not the live bus.
  assign xfer.conf    = conf_q;
  assign ss           = ss_q;

  spi_xcvr #(
    .clkfreq(clkfreq),
    .speed  (speed)
  ) xcvr_i (
    .clk  (clk),
    .rst_n(rst_n),
    .xfer (xfer),
    .miso (miso),
    .mosi (mosi),
    .sclk (sclk)
  );

endmodule

// File: logic/spi_periph.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_periph (
  input  logic                clk,
  input  logic                rst_n,
  // host bus.
  input  logic                select,
  input  logic                write,
  input  spi_pkg::reg_addr_t  address,
  input  spi_pkg::data_word_t data_in,
  output spi_pkg::data_word_t data_out,
  // spi pins.
  input  logic                miso,
  output logic                mosi,
  output logic                sclk,
  output logic                ss
);

  // divider is fixed here from the defaults.
  spi_master #(
    .clkfreq(`SPI_CLKFREQ),
    .speed  (`SPI_SPEED)
  ) master_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .select  (select),
    .write   (write),
    .address (address),
    .data_in (data_in),
    .data_out(data_out),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk),
    .ss      (ss)
  );

endmodule

// File: verification/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model (
  input  logic               sclk,
  input  logic               mosi,
  input  logic               ss,
  input  logic               cpol,
  input  logic               cpha,
  input  logic               lsb_first,
  input  spi_pkg::spi_byte_t reply,
  output logic               miso,
  output spi_pkg::spi_byte_t rx_byte,
  output int                 byte_cnt,
  output int                 edge_cnt
);
  import spi_pkg::*;

  logic [3:0] lead_cnt;    // leading sclk edges in this byte.
  logic [3:0] trail_cnt;   // trailing sclk edges in this byte.
  logic [2:0] out_idx;
  spi_byte_t  rx_sr;

  // bit k of a byte in wire order.
  function automatic logic wire_bit(spi_byte_t b, logic [2:0] k, logic lsb);
    logic bit_val;
    if (lsb) begin
      bit_val = b[k];
    end else begin
      bit_val = b[3'd7 - k];
    end
    return bit_val;
  endfunction

  task automatic capture_bit(input logic [3:0] k);
    if (lsb_first) begin
      rx_sr[k[2:0]] = mosi;
    end else begin
      rx_sr[3'd7 - k[2:0]] = mosi;
    end
  endtask

  // cpha 1 puts bit 0 out on the first leading edge.
  assign out_idx = cpha ? ((lead_cnt == 4'd0) ? 3'd0 : lead_cnt[2:0] - 3'd1) : trail_cnt[2:0];
  assign miso    = ss ? 1'b0 : wire_bit(reply, out_idx, lsb_first);

  always @(posedge sclk or negedge sclk or posedge ss) begin
    if (ss) begin
      lead_cnt  = '0;   // deselected, counts start over.
      trail_cnt = '0;
      byte_cnt  = 0;
      edge_cnt  = 0;
    end else if (sclk != cpol) begin
      edge_cnt = edge_cnt + 1;
      if (!cpha) begin
        capture_bit(lead_cnt);
      end
      lead_cnt = lead_cnt + 4'd1;
    end else begin
      edge_cnt = edge_cnt + 1;
      if (cpha) begin
        capture_bit(trail_cnt);
      end
      trail_cnt = trail_cnt + 4'd1;
      if (trail_cnt == 4'd8) begin
        rx_byte   = rx_sr;   // eighth trailing edge ends the byte.
        byte_cnt  = byte_cnt + 1;
        lead_cnt  = '0;
        trail_cnt = '0;
      end
    end
  end

endmodule

// File: verification/spi_periph_tb.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_periph_tb;
  import spi_pkg::*;

  localparam int poll_limit = 400;

  logic       clk;
  logic       rst_n;
  logic       select;
  logic       write;
  reg_addr_t  address;
  data_word_t data_in;
  data_word_t data_out;
  logic       miso;
  logic       mosi;
  logic       sclk;
  logic       ss;
  logic       slave_cpol;
  logic       slave_cpha;
  logic       slave_lsb;
  spi_byte_t  slave_reply;
  spi_byte_t  slave_rx;
  int         slave_bytes;
  int         slave_edges;
  integer     seed;
  int         errors;
  int         tests_run;
  int         tests_failed;

  spi_periph spi_periph_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .select  (select),
    .write   (write),
    .address (address),
    .data_in (data_in),
    .data_out(data_out),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk),
    .ss      (ss)
  );

  spi_slave_model slave_i (
    .sclk     (sclk),
    .mosi     (mosi),
    .ss       (ss),
    .cpol     (slave_cpol),
    .cpha     (slave_cpha),
    .lsb_first(slave_lsb),
    .reply    (slave_reply),
    .miso     (miso),
    .rx_byte  (slave_rx),
    .byte_cnt (slave_bytes),
    .edge_cnt (slave_edges)
  );

  always #2 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reporting and bus access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic report_mismatch(input string name, input data_word_t got,
                                 input data_word_t exp);
    $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // all bus tasks start and end 1 ns after a rising edge.
  task automatic bus_write(input reg_addr_t addr, input data_word_t data);
    select  = 1'b1;
    write   = 1'b1;
    address = addr;
    data_in = data;
    @(posedge clk);
    #1;
    select  = 1'b0;
    write   = 1'b0;
    data_in = '0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output data_word_t data);
    select  = 1'b1;
    write   = 1'b0;
    address = addr;
    #2;
    data = data_out;   // sampled mid cycle.
    @(posedge clk);
    #1;
    select = 1'b0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_complete(output data_word_t status, output logic ok);
    int polls;
    polls  = 0;
    ok     = 1'b0;
    status = '0;
    while (!ok && (polls < poll_limit)) begin
      bus_read(`SPI_ADDR_DATA, status);
      polls++;
      if (status[15:14] == ST_COMPLETE) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("timeout: status never showed a completed transfer");
      errors++;
    end
  endtask

  // one byte in the given mode, checked at both ends.
  task automatic run_transfer(input logic cpol, input logic cpha, input logic lsb);
    spi_byte_t  tx;
    data_word_t status;
    logic       ok;
    slave_cpol = cpol;
    slave_cpha = cpha;
    slave_lsb  = lsb;
    bus_write(`SPI_ADDR_SS, 16'h0001);
    bus_write(`SPI_ADDR_CONF, {13'h0000, lsb, cpol, cpha});
    idle_cycle();   // sclk settles at the new idle level.
    idle_cycle();
    bus_write(`SPI_ADDR_SS, 16'h0000);
    tx          = spi_byte_t'($random(seed));
    slave_reply = spi_byte_t'($random(seed));
    bus_write(`SPI_ADDR_DATA, {spi_byte_t'($random(seed)), tx});
    wait_complete(status, ok);
    if (ok) begin
      if (slave_rx !== tx) begin
        report_mismatch("slave rx_byte", {8'h00, slave_rx}, {8'h00, tx});
      end
      if (status[7:0] !== slave_reply) begin
        report_mismatch("status rx_byte", {8'h00, status[7:0]}, {8'h00, slave_reply});
      end
      if (slave_bytes != 1) begin
        report_mismatch("slave byte count", data_word_t'(slave_bytes), 16'h0001);
      end
    end
    idle_cycle();   // release back to idle.
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_values();
    int         errors_before;
    data_word_t rd;
    errors_before = errors;
    if (data_out !== 16'h0000) begin
      report_mismatch("data_out without read", data_out, 16'h0000);
    end
    bus_read(`SPI_ADDR_DATA, rd);
    if (rd !== 16'h0000) report_mismatch("status", rd, 16'h0000);
    bus_read(`SPI_ADDR_SS, rd);
    if (rd !== 16'h0001) report_mismatch("ss register", rd, 16'h0001);
    bus_read(`SPI_ADDR_CONF, rd);
    if (rd !== 16'h0000) report_mismatch("conf register", rd, 16'h0000);
    if (ss !== 1'b1) report_mismatch("ss pin", {15'h0000, ss}, 16'h0001);
    if (sclk !== 1'b0) report_mismatch("sclk pin", {15'h0000, sclk}, 16'h0000);
    if (mosi !== 1'b0) report_mismatch("mosi pin", {15'h0000, mosi}, 16'h0000);
    finish_test("reset_values", errors_before);
  endtask

  task automatic test_register_readback();
    int         errors_before;
    data_word_t rd;
    data_word_t conf_val;
    errors_before = errors;
    bus_write(`SPI_ADDR_SS, 16'h0000);
    bus_read(`SPI_ADDR_SS, rd);
    if (rd !== 16'h0000) report_mismatch("ss register", rd, 16'h0000);
    if (ss !== 1'b0) report_mismatch("ss pin", {15'h0000, ss}, 16'h0000);
    bus_write(`SPI_ADDR_SS, 16'h0001);
    bus_read(`SPI_ADDR_SS, rd);
    if (rd !== 16'h0001) report_mismatch("ss register", rd, 16'h0001);
    if (ss !== 1'b1) report_mismatch("ss pin", {15'h0000, ss}, 16'h0001);
    conf_val = data_word_t'($random(seed));   // spare bits are kept too.
    bus_write(`SPI_ADDR_CONF, conf_val);
    bus_read(`SPI_ADDR_CONF, rd);
    if (rd !== conf_val) report_mismatch("conf register", rd, conf_val);
    bus_write(`SPI_ADDR_CONF, 16'h0000);
    bus_read(4'h6, rd);
    if (rd !== 16'h0000) report_mismatch("unused address 0x6", rd, 16'h0000);
    bus_read(4'hE, rd);
    if (rd !== 16'h0000) report_mismatch("unused address 0xe", rd, 16'h0000);
    finish_test("register_readback", errors_before);
  endtask

  task automatic test_all_modes();
    int errors_before;
    errors_before = errors;
    for (int mode = 0; mode < 4; mode++) begin
      run_transfer(mode[1], mode[0], 1'b0);
    end
    finish_test("all_modes", errors_before);
  endtask

  task automatic test_lsb_first();
    int errors_before;
    errors_before = errors;
    run_transfer(1'b0, 1'b0, 1'b1);
    run_transfer(1'b1, 1'b1, 1'b1);
    finish_test("lsb_first", errors_before);
  endtask

  task automatic test_status_cycle();
    int         errors_before;
    spi_byte_t  first;
    spi_byte_t  second;
    data_word_t status;
    data_word_t rd;
    logic       ok;
    errors_before = errors;
    slave_cpol = 1'b0;
    slave_cpha = 1'b0;
    slave_lsb  = 1'b0;
    bus_write(`SPI_ADDR_SS, 16'h0001);
    bus_write(`SPI_ADDR_CONF, 16'h0000);
    idle_cycle();
    bus_write(`SPI_ADDR_SS, 16'h0000);
    first       = spi_byte_t'($random(seed));
    second      = ~first;   // must differ from the byte in flight.
    slave_reply = spi_byte_t'($random(seed));
    bus_write(`SPI_ADDR_DATA, {8'h00, first});
    bus_read(`SPI_ADDR_DATA, rd);
    if (rd[15:14] !== ST_BUSY) begin
      report_mismatch("status state", {14'h0000, rd[15:14]}, {14'h0000, ST_BUSY});
    end
    bus_write(`SPI_ADDR_DATA, {8'h00, second});   // dropped while busy.
    wait_complete(status, ok);
    if (ok) begin
      bus_read(`SPI_ADDR_DATA, rd);
      if (rd[15:14] !== ST_RELEASE) begin
        report_mismatch("status state", {14'h0000, rd[15:14]}, {14'h0000, ST_RELEASE});
      end
      idle_cycle();
      bus_read(`SPI_ADDR_DATA, rd);
      if (rd !== {ST_IDLE, 6'h00, slave_reply}) begin
        report_mismatch("status", rd, {ST_IDLE, 6'h00, slave_reply});
      end
      if (slave_rx !== first) begin
        report_mismatch("slave rx_byte", {8'h00, slave_rx}, {8'h00, first});
      end
      if (slave_bytes != 1) begin
        report_mismatch("slave byte count", data_word_t'(slave_bytes), 16'h0001);
      end
      if (slave_edges != 16) begin
        report_mismatch("sclk edge count", data_word_t'(slave_edges), 16'h0010);
      end
    end
    bus_write(`SPI_ADDR_SS, 16'h0001);
    finish_test("status_cycle", errors_before);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    seed         = 32'h806b6557;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    select       = 1'b0;
    write        = 1'b0;
    address      = '0;
    data_in      = '0;
    slave_cpol   = 1'b0;
    slave_cpha   = 1'b0;
    slave_lsb    = 1'b0;
    slave_reply  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_values();
    test_register_readback();
    test_all_modes();
    test_lsb_first();
    test_status_cycle();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: spi_periph.f
+incdir+include
logic/spi_pkg.sv
logic/spi_xfer_if.sv
logic/spi_clk_gen.sv
logic/spi_xcvr.sv
logic/spi_master.sv
logic/spi_periph.sv
verification/spi_slave_model.sv
verification/spi_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f spi_periph.f --top-module spi_periph_tb -Mdir obj_dir

out=$(./obj_dir/Vspi_periph_tb)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
